/* core_pkg.sv */
`default_nettype none

package core_pkg;

  localparam int NUM_REGS = 32;

  // instruction field positions
  localparam int OPCODE_MSB = 31;
  localparam int OPCODE_LSB = 26;
  localparam int RS_MSB     = 25;
  localparam int RS_LSB     = 21;
  localparam int RT_MSB     = 20;
  localparam int RT_LSB     = 16;
  localparam int RD_MSB     = 15;
  localparam int RD_LSB     = 11;
  localparam int SHAMT_MSB  = 10;
  localparam int SHAMT_LSB  = 6;
  localparam int IMM_MSB    = 15;
  localparam int IMM_LSB    = 0;

  typedef logic [31:0] data_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [15:0] imm_t;
  typedef logic [4:0]  shamt_t;

  typedef enum logic [5:0] {
    OP_NOP  = 6'h00,
    OP_ADD  = 6'h01,
    OP_SUB  = 6'h02,
    OP_AND  = 6'h03,
    OP_OR   = 6'h04,
    OP_XOR  = 6'h05,
    // rd = rs << shamt
    OP_SLL  = 6'h06,
    OP_ADDI = 6'h08,
    OP_ORI  = 6'h09
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLL = 3'd5
  } alu_op_e;

  typedef struct packed {
    logic  valid;
    inst_t inst;
  } issue_slot_t;

  typedef struct packed {
    logic      valid;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t dst;
    data_t     rs_data;
    data_t     rt_data;
    imm_t      imm;
    shamt_t    shamt;
    alu_op_e   alu_op;
    logic      alu_src;
    logic      reg_write;
  } id_ex_t;

  typedef struct packed {
    logic      valid;
    logic      reg_write;
    reg_addr_t dst;
    data_t     data;
  } wb_t;

  ////////////////////////////////////////////////////////////
  // decode helpers shared by steering and decode

  function automatic opcode_e opcode_of(inst_t inst);
    return opcode_e'(inst[OPCODE_MSB:OPCODE_LSB]);
  endfunction

  // unknown opcodes behave as nop
  function automatic logic writes_reg(opcode_e op);
    case (op)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_ADDI, OP_ORI: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // immediate ops write rt, register ops write rd
  function automatic reg_addr_t dest_reg(inst_t inst);
    case (opcode_of(inst))
      OP_ADDI, OP_ORI: return inst[RT_MSB:RT_LSB];
      default: return inst[RD_MSB:RD_LSB];
    endcase
  endfunction

  function automatic logic wb_writes(wb_t wb);
    return wb.valid && wb.reg_write && (wb.dst != '0);
  endfunction

endpackage

`default_nettype wire

/* steer_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module steer_fsm (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          fetch_valid,
  input  wire core_pkg::inst_t [1:0]   fetch_pair,
  output logic                         fetch_ready,
  output core_pkg::issue_slot_t        issue0,
  output core_pkg::issue_slot_t        issue1
);

  typedef enum logic {
    PAIR,
    SECOND
  } state_e;

  state_e state;
  state_e state_next;

  core_pkg::inst_t     held_inst;
  core_pkg::reg_addr_t dst0;
  core_pkg::reg_addr_t rs1;
  core_pkg::reg_addr_t rt1;
  logic                writes0;
  logic                accept;
  logic                dep;

  assign fetch_ready = (state == PAIR);
  assign accept      = fetch_valid && fetch_ready;

  ////////////////////////////////////////////////////////////
  // intra-pair dependency

  assign dst0    = core_pkg::dest_reg(fetch_pair[0]);
  assign writes0 = core_pkg::writes_reg(core_pkg::opcode_of(fetch_pair[0]));
  assign rs1     = fetch_pair[1][core_pkg::RS_MSB:core_pkg::RS_LSB];
  assign rt1     = fetch_pair[1][core_pkg::RT_MSB:core_pkg::RT_LSB];

  // r0 writes never create a dependency
  assign dep = writes0 && (dst0 != '0) && ((rs1 == dst0) || (rt1 == dst0));

  always_comb begin
    state_next = state;
    case (state)
      PAIR: begin
        if (accept && dep) begin
          state_next = SECOND;
        end
      end
      SECOND: state_next = PAIR;
      default: state_next = PAIR;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // issue registers

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state        <= PAIR;
      issue0.valid <= 1'b0;
      issue1.valid <= 1'b0;
    end else begin
      state <= state_next;
      if (state == SECOND) begin
        // slot 1 of a split pair goes alone on pipe 1
        issue0.valid <= 1'b0;
        issue1.valid <= 1'b1;
        issue1.inst  <= held_inst;
      end else begin
        issue0.valid <= accept;
        issue0.inst  <= fetch_pair[0];
        issue1.valid <= accept && !dep;
        issue1.inst  <= fetch_pair[1];
      end
    end
  end

  // held copy of slot 1 while slot 0 goes first
  always_ff @(posedge clk) begin
    if (accept && dep) begin
      held_inst <= fetch_pair[1];
    end
  end

endmodule

`default_nettype wire

/* decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire core_pkg::issue_slot_t   issue,
  output core_pkg::reg_addr_t          rs_addr,
  output core_pkg::reg_addr_t          rt_addr,
  input  wire core_pkg::data_t         rs_data,
  input  wire core_pkg::data_t         rt_data,
  output core_pkg::id_ex_t             id_ex
);

  core_pkg::opcode_e op;
  core_pkg::alu_op_e alu_op;
  logic              alu_src;
  logic              reg_write;
  core_pkg::id_ex_t  id_ex_d;

  assign op = core_pkg::opcode_of(issue.inst);

  // register reads go out straight from the issue slot
  assign rs_addr = issue.inst[core_pkg::RS_MSB:core_pkg::RS_LSB];
  assign rt_addr = issue.inst[core_pkg::RT_MSB:core_pkg::RT_LSB];

  assign reg_write = issue.valid && core_pkg::writes_reg(op);

  ////////////////////////////////////////////////////////////
  // control

  always_comb begin
    alu_op  = core_pkg::ALU_ADD;
    alu_src = 1'b0;
    case (op)
      core_pkg::OP_ADD: alu_op = core_pkg::ALU_ADD;
      core_pkg::OP_SUB: alu_op = core_pkg::ALU_SUB;
      core_pkg::OP_AND: alu_op = core_pkg::ALU_AND;
      core_pkg::OP_OR:  alu_op = core_pkg::ALU_OR;
      core_pkg::OP_XOR: alu_op = core_pkg::ALU_XOR;
      core_pkg::OP_SLL: alu_op = core_pkg::ALU_SLL;
      core_pkg::OP_ADDI: begin
        alu_op  = core_pkg::ALU_ADD;
        alu_src = 1'b1;
      end
      core_pkg::OP_ORI: begin
        alu_op  = core_pkg::ALU_OR;
        alu_src = 1'b1;
      end
      default: begin
        alu_op  = core_pkg::ALU_ADD;
        alu_src = 1'b0;
      end
    endcase
  end

  always_comb begin
    id_ex_d.valid     = issue.valid;
    id_ex_d.rs        = rs_addr;
    id_ex_d.rt        = rt_addr;
    id_ex_d.dst       = core_pkg::dest_reg(issue.inst);
    id_ex_d.rs_data   = rs_data;
    id_ex_d.rt_data   = rt_data;
    id_ex_d.imm       = issue.inst[core_pkg::IMM_MSB:core_pkg::IMM_LSB];
    id_ex_d.shamt     = issue.inst[core_pkg::SHAMT_MSB:core_pkg::SHAMT_LSB];
    id_ex_d.alu_op    = alu_op;
    id_ex_d.alu_src   = alu_src;
    id_ex_d.reg_write = reg_write;
  end

  ////////////////////////////////////////////////////////////
  // id/ex register

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_ex.valid     <= 1'b0;
      id_ex.reg_write <= 1'b0;
    end else begin
      id_ex <= id_ex_d;
    end
  end

endmodule

`default_nettype wire

/* register_file.sv */
`timescale 1ns/1ns
`default_nettype none

module register_file #(
  parameter core_pkg::data_t RESET_VALUE = '0
) (
  input  wire                              clk,
  input  wire                              rst_n,
  input  wire core_pkg::reg_addr_t [3:0]   rd_addr,
  output core_pkg::data_t [3:0]            rd_data,
  input  wire core_pkg::wb_t               wr0,
  input  wire core_pkg::wb_t               wr1
);

  core_pkg::data_t regs [core_pkg::NUM_REGS];

  logic wr0_en;
  logic wr1_en;

  assign wr0_en = core_pkg::wb_writes(wr0);
  assign wr1_en = core_pkg::wb_writes(wr1);

  // wr1 is the younger result and lands last
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
        regs[i] <= RESET_VALUE;
      end
    end else begin
      if (wr0_en) begin
        regs[wr0.dst] <= wr0.data;
      end
      if (wr1_en) begin
        regs[wr1.dst] <= wr1.data;
      end
    end
  end

  // read ports with same-cycle write bypass
  always_comb begin
    for (int p = 0; p < 4; p++) begin
      if (rd_addr[p] == '0) begin
        rd_data[p] = '0;
      end else if (wr1_en && (wr1.dst == rd_addr[p])) begin
        rd_data[p] = wr1.data;
      end else if (wr0_en && (wr0.dst == rd_addr[p])) begin
        rd_data[p] = wr0.data;
      end else begin
        rd_data[p] = regs[rd_addr[p]];
      end
    end
  end

endmodule

`default_nettype wire

/* execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire core_pkg::id_ex_t    id_ex,
  input  wire core_pkg::wb_t       fwd0,
  input  wire core_pkg::wb_t       fwd1,
  output core_pkg::wb_t            wb
);

  core_pkg::data_t op_a;
  core_pkg::data_t op_rt;
  core_pkg::data_t op_b;
  core_pkg::data_t result;

  ////////////////////////////////////////////////////////////
  // forwarding

  // newest value wins since pipe 1 is younger than pipe 0
  function automatic core_pkg::data_t forward(
    core_pkg::reg_addr_t addr,
    core_pkg::data_t     reg_value,
    core_pkg::wb_t       f0,
    core_pkg::wb_t       f1
  );
    if (core_pkg::wb_writes(f1) && (f1.dst == addr)) begin
      return f1.data;
    end
    if (core_pkg::wb_writes(f0) && (f0.dst == addr)) begin
      return f0.data;
    end
    return reg_value;
  endfunction

  assign op_a  = forward(id_ex.rs, id_ex.rs_data, fwd0, fwd1);
  assign op_rt = forward(id_ex.rt, id_ex.rt_data, fwd0, fwd1);

  // immediate is zero extended
  assign op_b = id_ex.alu_src ? {16'h0000, id_ex.imm} : op_rt;

  ////////////////////////////////////////////////////////////
  // alu

  always_comb begin
    case (id_ex.alu_op)
      core_pkg::ALU_ADD: result = op_a + op_b;
      core_pkg::ALU_SUB: result = op_a - op_b;
      core_pkg::ALU_AND: result = op_a & op_b;
      core_pkg::ALU_OR:  result = op_a | op_b;
      core_pkg::ALU_XOR: result = op_a ^ op_b;
      core_pkg::ALU_SLL: result = op_a << id_ex.shamt;
      default:           result = '0;
    endcase
  end

  // writeback register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb.valid     <= 1'b0;
      wb.reg_write <= 1'b0;
    end else begin
      wb.valid     <= id_ex.valid;
      wb.reg_write <= id_ex.valid && id_ex.reg_write;
      wb.dst       <= id_ex.dst;
      wb.data      <= result;
    end
  end

endmodule

`default_nettype wire

/* dual_issue_core.sv */
`timescale 1ns/1ns
`default_nettype none

module dual_issue_core #(
  parameter core_pkg::data_t RESET_VALUE = '0
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          fetch_valid,
  input  wire core_pkg::inst_t [1:0]   fetch_pair,
  output logic                         fetch_ready,
  output core_pkg::wb_t                wb0,
  output core_pkg::wb_t                wb1
);

  core_pkg::issue_slot_t         issue0;
  core_pkg::issue_slot_t         issue1;
  core_pkg::id_ex_t              id_ex0;
  core_pkg::id_ex_t              id_ex1;
  core_pkg::reg_addr_t [3:0]     rd_addr;
  core_pkg::data_t [3:0]         rd_data;

  steer_fsm steer_fsm_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_valid (fetch_valid),
    .fetch_pair  (fetch_pair),
    .fetch_ready (fetch_ready),
    .issue0      (issue0),
    .issue1      (issue1)
  );

  ////////////////////////////////////////////////////////////
  // read ports 0/1 serve pipe 0 and 2/3 serve pipe 1

  decode_stage decode_stage0_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .issue   (issue0),
    .rs_addr (rd_addr[0]),
    .rt_addr (rd_addr[1]),
    .rs_data (rd_data[0]),
    .rt_data (rd_data[1]),
    .id_ex   (id_ex0)
  );

  decode_stage decode_stage1_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .issue   (issue1),
    .rs_addr (rd_addr[2]),
    .rt_addr (rd_addr[3]),
    .rs_data (rd_data[2]),
    .rt_data (rd_data[3]),
    .id_ex   (id_ex1)
  );

  register_file #(
    .RESET_VALUE (RESET_VALUE)
  ) register_file_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .wr0     (wb0),
    .wr1     (wb1)
  );

  ////////////////////////////////////////////////////////////
  // both execute pipes see both writeback registers

  execute_stage execute_stage0_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .id_ex (id_ex0),
    .fwd0  (wb0),
    .fwd1  (wb1),
    .wb    (wb0)
  );

  execute_stage execute_stage1_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .id_ex (id_ex1),
    .fwd0  (wb0),
    .fwd1  (wb1),
    .wb    (wb1)
  );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // release just after an edge so the first active cycle is clean
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* tb_dual_issue_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_dual_issue_core;

  localparam int NUM_RANDOM = 40;

  typedef struct packed {
    core_pkg::inst_t i0;
    core_pkg::inst_t i1;
    core_pkg::data_t exp0;
    core_pkg::data_t exp1;
    logic            split;
    logic [1:0]      idle;
  } row_t;

  typedef struct packed {
    core_pkg::reg_addr_t dst;
    core_pkg::data_t     data;
    logic                pipe;
    logic [31:0]         cyc;
  } expect_t;

  logic                  clk;
  logic                  rst_n;
  logic                  fetch_valid;
  core_pkg::inst_t [1:0] fetch_pair;
  logic                  fetch_ready;
  core_pkg::wb_t         wb0;
  core_pkg::wb_t         wb1;

  row_t            rows[$];
  expect_t         expect_q[$];
  core_pkg::data_t model_regs [32];
  integer          seed = 32'h21998e80;
  int              cyc = 0;
  int              cycle_limit = 0;
  int              ready_low_cyc = -1;
  int              checks = 0;
  int              errors = 0;

  tb_clock_gen #(
    .PERIOD_NS    (4),
    .RESET_CYCLES (8)
  ) tb_clock_gen_inst (
    .clk   (clk),
    .rst_n (rst_n)
  );

  dual_issue_core #(
    .RESET_VALUE (32'h0000_0000)
  ) dual_issue_core_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_valid (fetch_valid),
    .fetch_pair  (fetch_pair),
    .fetch_ready (fetch_ready),
    .wb0         (wb0),
    .wb1         (wb1)
  );

  always @(posedge clk) cyc <= cyc + 1;

  ////////////////////////////////////////////////////////////
  // encoding and reference model

  function automatic core_pkg::inst_t r_inst(core_pkg::opcode_e op, logic [4:0] rd,
                                             logic [4:0] rs, logic [4:0] rt,
                                             logic [4:0] shamt);
    return {op, rs, rt, rd, shamt, 6'h00};
  endfunction

  function automatic core_pkg::inst_t i_inst(core_pkg::opcode_e op, logic [4:0] rt,
                                             logic [4:0] rs, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic writes_result(core_pkg::inst_t inst);
    case (inst[31:26])
      core_pkg::OP_ADD, core_pkg::OP_SUB, core_pkg::OP_AND, core_pkg::OP_OR,
      core_pkg::OP_XOR, core_pkg::OP_SLL, core_pkg::OP_ADDI, core_pkg::OP_ORI: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [4:0] dest_of(core_pkg::inst_t inst);
    if (inst[31:26] == core_pkg::OP_ADDI || inst[31:26] == core_pkg::OP_ORI) begin
      return inst[20:16];
    end
    return inst[15:11];
  endfunction

  // slot 1 reading slot 0's nonzero destination forces a split
  function automatic logic needs_split(core_pkg::inst_t i0, core_pkg::inst_t i1);
    logic [4:0] dst;
    dst = dest_of(i0);
    return writes_result(i0) && (dst != 5'd0) && (i1[25:21] == dst || i1[20:16] == dst);
  endfunction

  function automatic core_pkg::data_t expected_result(core_pkg::inst_t inst);
    core_pkg::data_t a;
    core_pkg::data_t b;
    core_pkg::data_t imm;
    a   = model_regs[inst[25:21]];
    b   = model_regs[inst[20:16]];
    imm = {16'h0000, inst[15:0]};
    case (inst[31:26])
      core_pkg::OP_ADD:  return a + b;
      core_pkg::OP_SUB:  return a - b;
      core_pkg::OP_AND:  return a & b;
      core_pkg::OP_OR:   return a | b;
      core_pkg::OP_XOR:  return a ^ b;
      core_pkg::OP_SLL:  return a << inst[10:6];
      core_pkg::OP_ADDI: return a + imm;
      core_pkg::OP_ORI:  return a | imm;
      default:           return 32'h0;
    endcase
  endfunction

  function automatic void model_update(core_pkg::inst_t inst, core_pkg::data_t value);
    if (writes_result(inst) && dest_of(inst) != 5'd0) begin
      model_regs[dest_of(inst)] = value;
    end
  endfunction

  // registers drawn from r0..r7 so hazards show up often
  function automatic core_pkg::inst_t random_inst();
    logic [31:0] r;
    int          pick;
    pick = int'($unsigned($random(seed)) % 9);
    r    = $random(seed);
    case (pick)
      0: return r_inst(core_pkg::OP_ADD, {2'b0, r[8:6]}, {2'b0, r[2:0]}, {2'b0, r[5:3]}, 5'd0);
      1: return r_inst(core_pkg::OP_SUB, {2'b0, r[8:6]}, {2'b0, r[2:0]}, {2'b0, r[5:3]}, 5'd0);
      2: return r_inst(core_pkg::OP_AND, {2'b0, r[8:6]}, {2'b0, r[2:0]}, {2'b0, r[5:3]}, 5'd0);
      3: return r_inst(core_pkg::OP_OR,  {2'b0, r[8:6]}, {2'b0, r[2:0]}, {2'b0, r[5:3]}, 5'd0);
      4: return r_inst(core_pkg::OP_XOR, {2'b0, r[8:6]}, {2'b0, r[2:0]}, {2'b0, r[5:3]}, 5'd0);
      5: return r_inst(core_pkg::OP_SLL, {2'b0, r[8:6]}, {2'b0, r[2:0]}, 5'd0, r[13:9]);
      6: return i_inst(core_pkg::OP_ADDI, {2'b0, r[5:3]}, {2'b0, r[2:0]}, r[31:16]);
      7: return i_inst(core_pkg::OP_ORI,  {2'b0, r[5:3]}, {2'b0, r[2:0]}, r[31:16]);
      default: return 32'h0000_0000;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus table

  function automatic void add_row(core_pkg::inst_t i0, core_pkg::inst_t i1,
                                  core_pkg::data_t exp0, core_pkg::data_t exp1,
                                  logic split, logic [1:0] idle);
    row_t row;
    row.i0    = i0;
    row.i1    = i1;
    row.exp0  = exp0;
    row.exp1  = exp1;
    row.split = split;
    row.idle  = idle;
    rows.push_back(row);
    model_update(i0, exp0);
    model_update(i1, exp1);
  endfunction

  function automatic void build_table();
    core_pkg::inst_t i0;
    core_pkg::inst_t i1;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = 32'h0;
    end
    // every register reads zero after reset
    for (int i = 0; i < 8; i++) begin
      add_row(r_inst(core_pkg::OP_OR, 5'd0, 5'(4 * i), 5'(4 * i + 1), 5'd0),
              r_inst(core_pkg::OP_OR, 5'd0, 5'(4 * i + 2), 5'(4 * i + 3), 5'd0),
              32'h0, 32'h0, 1'b0, 2'd0);
    end
    // independent pairs, all ops, forwarding and bypass distances
    add_row(i_inst(core_pkg::OP_ADDI, 5'd1, 5'd0, 16'h1234),
            i_inst(core_pkg::OP_ORI, 5'd2, 5'd0, 16'hf0f0), 32'h1234, 32'hf0f0, 1'b0, 2'd0);
    add_row(i_inst(core_pkg::OP_ADDI, 5'd3, 5'd0, 16'h8001),
            i_inst(core_pkg::OP_ADDI, 5'd4, 5'd0, 16'hffff), 32'h8001, 32'hffff, 1'b0, 2'd0);
    add_row(r_inst(core_pkg::OP_ADD, 5'd5, 5'd1, 5'd2, 5'd0),
            r_inst(core_pkg::OP_SUB, 5'd6, 5'd3, 5'd4, 5'd0), 32'h10324, 32'hffff8002,
            1'b0, 2'd0);
    add_row(r_inst(core_pkg::OP_AND, 5'd7, 5'd2, 5'd4, 5'd0),
            r_inst(core_pkg::OP_OR, 5'd8, 5'd1, 5'd3, 5'd0), 32'hf0f0, 32'h9235, 1'b0, 2'd0);
    add_row(r_inst(core_pkg::OP_XOR, 5'd9, 5'd5, 5'd6, 5'd0),
            r_inst(core_pkg::OP_SLL, 5'd10, 5'd1, 5'd0, 5'd4), 32'hfffe8326, 32'h12340,
            1'b0, 2'd0);
    // split pair, then readers of pipe 1's result
    add_row(i_inst(core_pkg::OP_ADDI, 5'd11, 5'd0, 16'h0010),
            r_inst(core_pkg::OP_ADD, 5'd12, 5'd11, 5'd8, 5'd0), 32'h10, 32'h9245, 1'b1, 2'd0);
    add_row(r_inst(core_pkg::OP_SUB, 5'd13, 5'd12, 5'd11, 5'd0),
            r_inst(core_pkg::OP_XOR, 5'd14, 5'd12, 5'd7, 5'd0), 32'h9235, 32'h62b5,
            1'b0, 2'd0);
    add_row(i_inst(core_pkg::OP_ORI, 5'd15, 5'd13, 16'h000f),
            r_inst(core_pkg::OP_AND, 5'd16, 5'd14, 5'd13, 5'd0), 32'h923f, 32'h0235,
            1'b0, 2'd0);
    // both slots write r17 and slot 1 wins
    add_row(i_inst(core_pkg::OP_ADDI, 5'd17, 5'd0, 16'h0aaa),
            r_inst(core_pkg::OP_OR, 5'd17, 5'd15, 5'd0, 5'd0), 32'h0aaa, 32'h923f, 1'b0, 2'd0);
    add_row(r_inst(core_pkg::OP_ADD, 5'd18, 5'd17, 5'd0, 5'd0), 32'h0, 32'h923f, 32'h0,
            1'b0, 2'd0);
    add_row(r_inst(core_pkg::OP_XOR, 5'd20, 5'd17, 5'd0, 5'd0), 32'h0, 32'h923f, 32'h0,
            1'b0, 2'd0);
    add_row(r_inst(core_pkg::OP_SUB, 5'd19, 5'd17, 5'd0, 5'd0), 32'h0, 32'h923f, 32'h0,
            1'b0, 2'd0);
    // r0 as destination stays invisible
    add_row(i_inst(core_pkg::OP_ADDI, 5'd0, 5'd0, 16'h5555),
            i_inst(core_pkg::OP_ORI, 5'd21, 5'd0, 16'h0001), 32'h5555, 32'h1, 1'b0, 2'd0);
    add_row(r_inst(core_pkg::OP_ADD, 5'd22, 5'd0, 5'd21, 5'd0),
            r_inst(core_pkg::OP_OR, 5'd23, 5'd0, 5'd0, 5'd0), 32'h1, 32'h0, 1'b0, 2'd0);
    add_row(i_inst(core_pkg::OP_ADDI, 5'd24, 5'd0, 16'h0002),
            r_inst(core_pkg::OP_ADD, 5'd25, 5'd0, 5'd0, 5'd0), 32'h2, 32'h0, 1'b0, 2'd0);
    // split through the rt field
    add_row(r_inst(core_pkg::OP_SLL, 5'd26, 5'd24, 5'd0, 5'd3),
            r_inst(core_pkg::OP_AND, 5'd27, 5'd11, 5'd26, 5'd0), 32'h10, 32'h10, 1'b1, 2'd0);
    for (int n = 0; n < NUM_RANDOM; n++) begin
      i0 = random_inst();
      i1 = random_inst();
      while (needs_split(i0, i1)) begin
        i1 = random_inst();
      end
      add_row(i0, i1, expected_result(i0), expected_result(i1), 1'b0,
              2'($unsigned($random(seed)) % 3));
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // driving and checking

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got 0x%h, expected 0x%h (cycle %0d)", name, got, exp, cyc);
    end
  endtask

  task automatic push_expect(input core_pkg::inst_t inst, input core_pkg::data_t value,
                             input logic pipe, input int retire_cyc);
    expect_t ent;
    if (writes_result(inst)) begin
      ent.dst  = dest_of(inst);
      ent.data = value;
      ent.pipe = pipe;
      ent.cyc  = 32'(retire_cyc);
      expect_q.push_back(ent);
    end
  endtask

  // called 1 ns after a rising edge
  task automatic send_row(input row_t row);
    int   k;
    logic ready;
    for (int i = 0; i < int'(row.idle); i++) begin
      @(posedge clk);
      #1;
    end
    fetch_valid   = 1'b1;
    fetch_pair[0] = row.i0;
    fetch_pair[1] = row.i1;
    ready = 1'b0;
    k     = 0;
    while (!ready) begin
      @(negedge clk);
      ready = fetch_ready;
      k     = cyc;
      @(posedge clk);
    end
    #1;
    fetch_valid = 1'b0;
    fetch_pair  = '0;
    if (row.split) begin
      ready_low_cyc = k + 1;
    end
    push_expect(row.i0, row.exp0, 1'b0, k + 3);
    push_expect(row.i1, row.exp1, 1'b1, row.split ? k + 4 : k + 3);
  endtask

  task automatic collect(input core_pkg::wb_t wb, input int pipe);
    expect_t ent;
    if (wb.valid && wb.reg_write) begin
      if (expect_q.size() == 0) begin
        errors++;
        $display("unexpected result on wb%0d at cycle %0d with nothing pending", pipe, cyc);
      end else begin
        ent = expect_q.pop_front();
        check_value($sformatf("wb%0d.dst", pipe), 32'(wb.dst), 32'(ent.dst));
        check_value($sformatf("wb%0d.data", pipe), wb.data, ent.data);
        check_value($sformatf("wb%0d port", pipe), 32'(pipe), 32'(ent.pipe));
        check_value($sformatf("wb%0d retire cycle", pipe), 32'(cyc), ent.cyc);
      end
    end
  endtask

  // outputs settle half a cycle after the edge
  always @(negedge clk) begin
    if (rst_n) begin
      check_value("fetch_ready", 32'(fetch_ready), 32'(cyc != ready_low_cyc));
      collect(wb0, 0);
      collect(wb1, 1);
      if (cyc > cycle_limit) begin
        $display("timeout after %0d cycles with %0d results still missing",
                 cycle_limit, expect_q.size());
        $display("*** FAILED ***");
        $finish;
      end
    end
  end

  initial begin
    fetch_valid = 1'b0;
    fetch_pair  = '0;
    build_table();
    cycle_limit = 4 * rows.size() + 40;
    wait (rst_n === 1'b1);
    @(negedge clk);
    check_value("wb0.valid", 32'(wb0.valid), 32'd0);
    check_value("wb1.valid", 32'(wb1.valid), 32'd0);
    @(posedge clk);
    #1;
    foreach (rows[i]) begin
      send_row(rows[i]);
    end
    while (expect_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (4) @(posedge clk);
    $display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
core_pkg.sv
steer_fsm.sv
decode_stage.sv
register_file.sv
execute_stage.sv
dual_issue_core.sv
tb_clock_gen.sv
tb_dual_issue_core.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0 --Wno-fatal
TOP       = tb_dual_issue_core
FLIST     = flist.f
OBJ_DIR   = obj_dir
PASS_MSG  = *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
